// File: design/pti_bus_pkg.sv
// Bus package for the parallel transfer interface
// Holds the memory bus and byte stream widths and the beat type
package pti_bus_pkg;

	// ------------------------------------------------------------
	// Memory bus
	// ------------------------------------------------------------

	// Data width of the bus master, one beat per cycle
	localparam int BUS_DW = 128;

	// Byte address width of the bus master
	localparam int BUS_AW = 32;

	// Number of stream bytes carried by one beat
	localparam int BEAT_BYTES = BUS_DW / 8;

	// ------------------------------------------------------------
	// Byte stream
	// ------------------------------------------------------------

	// Width of the parallel byte port in both directions
	localparam int BYTE_W = 8;

	// ASCII end of transmission, halts the receive stream when enabled
	localparam logic [BYTE_W-1:0] EOT_CODE = 8'h04;

	// Byte k of a beat is the k-th byte in stream order, bits 8k+7:8k
	typedef logic [BUS_DW-1:0] beat_t;

endpackage

// File: design/pti_reg_pkg.sv
// Register map of the parallel transfer interface slave port
// Slot numbers, control bit positions and the software reset length
package pti_reg_pkg;

	// Slave data width and slot address width
	localparam int REG_DW = 64;
	localparam int REG_AW = 3;

	// ------------------------------------------------------------
	// Register slots
	// ------------------------------------------------------------
	localparam logic [REG_AW-1:0] REG_DST_ADR = 3'd0;
	localparam logic [REG_AW-1:0] REG_DST_CNT = 3'd1;
	localparam logic [REG_AW-1:0] REG_SRC_ADR = 3'd2;
	localparam logic [REG_AW-1:0] REG_SRC_CNT = 3'd3;
	localparam logic [REG_AW-1:0] REG_CTRL = 3'd4;
	// Destination threshold in the upper word, source in the lower
	localparam logic [REG_AW-1:0] REG_THRES = 3'd5;
	localparam logic [REG_AW-1:0] REG_STAT = 3'd7;

	// ------------------------------------------------------------
	// Control register bits, one per byte lane
	// ------------------------------------------------------------
	localparam int CTL_RD_STREAM = 0;
	localparam int CTL_WR_STREAM = 8;
	localparam int CTL_SWRST = 24;
	localparam int CTL_SIRQ_EN = 32;
	localparam int CTL_DIRQ_EN = 40;
	localparam int CTL_CHECK_EOT = 48;

	// Length of the buffer reset that a software reset triggers
	localparam int SWRST_CYCLES = 8;

endpackage

// File: design/pti_dma_if.sv
// DMA channel interface between the register decode and the bus master
// Carries stream enables, transfer addresses and beat completion pulses
`timescale 1ns/1ps

interface pti_dma_if;
	import pti_bus_pkg::*;

	// Next memory addresses for the receive and transmit directions
	logic [BUS_AW-1:0] dst_adr;
	logic [BUS_AW-1:0] src_adr;

	// Counts that have run out stop further bus cycles
	logic dst_cnt_zero;
	logic src_cnt_zero;

	// Stream enables from the control register
	logic rd_stream;
	logic wr_stream;

	// One-cycle pulses, one per acknowledged beat
	logic wr_beat_done;
	logic rd_beat_done;

	modport regs (
		output dst_adr, src_adr, dst_cnt_zero, src_cnt_zero, rd_stream, wr_stream,
		input wr_beat_done, rd_beat_done
	);

	modport master (
		input dst_adr, src_adr, dst_cnt_zero, src_cnt_zero, rd_stream, wr_stream,
		output wr_beat_done, rd_beat_done
	);

endinterface

// File: design/pti_regs.sv
// Register decode for the parallel transfer interface
// Holds addresses, counts, thresholds and control, and raises the interrupts
`timescale 1ns/1ps

module pti_regs (
	input  logic clk,
	input  logic rst_i,
	input  logic s_cs_i,
	input  logic s_we_i,
	input  logic [pti_reg_pkg::REG_DW/8-1:0] s_sel_i,
	input  logic [pti_reg_pkg::REG_AW-1:0] s_adr_i,
	input  logic [pti_reg_pkg::REG_DW-1:0] s_dat_i,
	output logic [pti_reg_pkg::REG_DW-1:0] s_dat_o,
	input  logic eot_i,
	input  logic [3:0] bus_stat_i,
	pti_dma_if.regs dma,
	output logic buf_rst_o,
	output logic check_eot_o,
	output logic sirq_o,
	output logic dirq_o
);
	import pti_bus_pkg::*;
	import pti_reg_pkg::*;

	logic wr;
	logic ctl_wr;
	logic ld_dst_cnt;
	logic ld_src_cnt;
	logic [BUS_AW-1:0] dst_cnt;
	logic [BUS_AW-1:0] src_cnt;
	logic [BUS_AW-1:0] dst_thres;
	logic [BUS_AW-1:0] src_thres;
	logic eot_seen;
	logic sirq_en, dirq_en;
	logic sirq, dirq;
	logic [$clog2(SWRST_CYCLES+1)-1:0] swrst_cnt;
	logic [REG_DW-1:0] ctl_rd;

	// Addresses and counts take a full low word write
	assign wr = s_cs_i & s_we_i;
	assign ctl_wr = wr && s_adr_i == REG_CTRL;
	assign ld_dst_cnt = wr && s_adr_i == REG_DST_CNT && &s_sel_i[3:0];
	assign ld_src_cnt = wr && s_adr_i == REG_SRC_CNT && &s_sel_i[3:0];

	assign dma.dst_cnt_zero = dst_cnt == '0;
	assign dma.src_cnt_zero = src_cnt == '0;

	// ------------------------------------------------------------
	// Address generators and transfer counts
	// ------------------------------------------------------------

	// Loaded values are beat aligned; each completed beat moves 16 bytes.
	// Once EOT is seen the destination address freezes on the last beat
	always_ff @(posedge clk) begin
		if (rst_i) begin
			dma.dst_adr <= '0;
			dma.src_adr <= '0;
			dst_cnt <= 32'hFFF0;
			src_cnt <= 32'hFFF0;
		end else begin
			if (wr && s_adr_i == REG_DST_ADR && &s_sel_i[3:0])
				dma.dst_adr <= {s_dat_i[BUS_AW-1:4], 4'h0};
			else if (dma.wr_beat_done && !dma.dst_cnt_zero && !eot_seen)
				dma.dst_adr <= dma.dst_adr + BUS_AW'(BEAT_BYTES);
			if (ld_dst_cnt)
				dst_cnt <= {s_dat_i[BUS_AW-1:4], 4'h0};
			else if (dma.wr_beat_done && !dma.dst_cnt_zero)
				dst_cnt <= dst_cnt - BUS_AW'(BEAT_BYTES);
			if (wr && s_adr_i == REG_SRC_ADR && &s_sel_i[3:0])
				dma.src_adr <= {s_dat_i[BUS_AW-1:4], 4'h0};
			else if (dma.rd_beat_done && !dma.src_cnt_zero)
				dma.src_adr <= dma.src_adr + BUS_AW'(BEAT_BYTES);
			if (ld_src_cnt)
				src_cnt <= {s_dat_i[BUS_AW-1:4], 4'h0};
			else if (dma.rd_beat_done && !dma.src_cnt_zero)
				src_cnt <= src_cnt - BUS_AW'(BEAT_BYTES);
		end
	end

	// ------------------------------------------------------------
	// Control register and stream state
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			dma.rd_stream <= 1'b0;
			dma.wr_stream <= 1'b0;
			eot_seen <= 1'b0;
			sirq_en <= 1'b0;
			dirq_en <= 1'b0;
			check_eot_o <= 1'b1;
		end else begin
			// The receive stream stops itself when the count runs out or on EOT
			if (ctl_wr && s_sel_i[CTL_RD_STREAM/8])
				dma.rd_stream <= s_dat_i[CTL_RD_STREAM];
			else if (dma.dst_cnt_zero || eot_i)
				dma.rd_stream <= 1'b0;
			// Any write of the receive enable rearms EOT detection
			if (ctl_wr && s_sel_i[CTL_RD_STREAM/8])
				eot_seen <= 1'b0;
			else if (eot_i)
				eot_seen <= 1'b1;
			if (ctl_wr && s_sel_i[CTL_WR_STREAM/8])
				dma.wr_stream <= s_dat_i[CTL_WR_STREAM];
			if (ctl_wr && s_sel_i[CTL_SIRQ_EN/8])
				sirq_en <= s_dat_i[CTL_SIRQ_EN];
			if (ctl_wr && s_sel_i[CTL_DIRQ_EN/8])
				dirq_en <= s_dat_i[CTL_DIRQ_EN];
			if (ctl_wr && s_sel_i[CTL_CHECK_EOT/8])
				check_eot_o <= s_dat_i[CTL_CHECK_EOT];
		end
	end

	// Software reset pulse is stretched so both buffers see a clean clear
	always_ff @(posedge clk) begin
		if (rst_i)
			swrst_cnt <= '0;
		else if (ctl_wr && s_sel_i[CTL_SWRST/8] && s_dat_i[CTL_SWRST])
			swrst_cnt <= ($bits(swrst_cnt))'(SWRST_CYCLES);
		else if (swrst_cnt != '0)
			swrst_cnt <= swrst_cnt - 1'b1;
	end
	assign buf_rst_o = swrst_cnt != '0;

	// Thresholds, written per 32-bit half
	always_ff @(posedge clk) begin
		if (rst_i) begin
			dst_thres <= '0;
			src_thres <= '0;
		end else if (wr && s_adr_i == REG_THRES) begin
			if (&s_sel_i[7:4])
				dst_thres <= s_dat_i[63:32];
			if (&s_sel_i[3:0])
				src_thres <= s_dat_i[31:0];
		end
	end

	// Sticky threshold flags, any control write acknowledges them
	always_ff @(posedge clk) begin
		if (rst_i || ctl_wr) begin
			sirq <= 1'b0;
			dirq <= 1'b0;
		end else begin
			if (src_cnt == src_thres)
				sirq <= 1'b1;
			if (dst_cnt == dst_thres)
				dirq <= 1'b1;
		end
	end
	assign sirq_o = sirq & sirq_en;
	assign dirq_o = dirq & dirq_en;

	// ------------------------------------------------------------
	// Slave read data
	// ------------------------------------------------------------
	always_comb begin
		ctl_rd = '0;
		ctl_rd[CTL_RD_STREAM] = dma.rd_stream;
		ctl_rd[CTL_WR_STREAM] = dma.wr_stream;
		ctl_rd[CTL_SIRQ_EN] = sirq_en;
		ctl_rd[CTL_DIRQ_EN] = dirq_en;
		ctl_rd[CTL_CHECK_EOT] = check_eot_o;
	end

	always_ff @(posedge clk) begin
		if (rst_i || !s_cs_i) begin
			s_dat_o <= '0;
		end else begin
			case (s_adr_i)
				REG_DST_ADR: s_dat_o <= REG_DW'(dma.dst_adr);
				REG_DST_CNT: s_dat_o <= REG_DW'(dst_cnt);
				REG_SRC_ADR: s_dat_o <= REG_DW'(dma.src_adr);
				REG_SRC_CNT: s_dat_o <= REG_DW'(src_cnt);
				REG_CTRL: s_dat_o <= ctl_rd;
				REG_THRES: s_dat_o <= {dst_thres, src_thres};
				REG_STAT: s_dat_o <= REG_DW'({eot_seen, bus_stat_i});
				default: s_dat_o <= '0;
			endcase
		end
	end

	// A completed beat never takes a count past zero
	assert property (@(posedge clk) disable iff (rst_i)
		dma.wr_beat_done && !ld_dst_cnt |=> dst_cnt <= $past(dst_cnt));
	assert property (@(posedge clk) disable iff (rst_i)
		dma.rd_beat_done && !ld_src_cnt |=> src_cnt <= $past(src_cnt));

	// The master finishes one beat at a time
	assert property (@(posedge clk) disable iff (rst_i)
		!(dma.wr_beat_done && dma.rd_beat_done));

endmodule

// File: design/pti_master.sv
// Memory bus master, one 128-bit read or write cycle at a time
// Writes receive beats to memory and reads transmit beats from it
`timescale 1ns/1ps

module pti_master (
	input  logic clk,
	input  logic rst_i,
	pti_dma_if.master dma,
	input  logic beat_rdy_i,
	input  pti_bus_pkg::beat_t beat_i,
	output logic beat_taken_o,
	input  logic room_i,
	output logic fill_o,
	output pti_bus_pkg::beat_t beat_o,
	output logic m_cyc_o,
	output logic m_stb_o,
	output logic m_we_o,
	output logic [pti_bus_pkg::BUS_AW-1:0] m_adr_o,
	output logic [pti_bus_pkg::BUS_DW-1:0] m_dat_o,
	input  logic [pti_bus_pkg::BUS_DW-1:0] m_dat_i,
	input  logic m_ack_i
);

	logic wr_pend;
	logic rd_pend;
	logic wr_dem;
	logic rd_dem;
	logic ack_q;
	logic ack_pe;

	// ------------------------------------------------------------
	// Bus cycle demands
	// ------------------------------------------------------------

	// Demands are remembered until their cycle is acknowledged, since a
	// cycle of the other kind may be running when they appear
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_pend <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			if (dma.wr_beat_done)
				wr_pend <= 1'b0;
			else if (beat_rdy_i)
				wr_pend <= 1'b1;
			if (dma.rd_beat_done)
				rd_pend <= 1'b0;
			else if (room_i && dma.wr_stream)
				rd_pend <= 1'b1;
		end
	end

	// Writes drain the receive buffer first; reads fill the transmit side
	assign wr_dem = (wr_pend | beat_rdy_i) & ~dma.dst_cnt_zero;
	assign rd_dem = (rd_pend | room_i) & dma.wr_stream & ~dma.src_cnt_zero;

	// ------------------------------------------------------------
	// Bus cycle control
	// ------------------------------------------------------------

	// Ack may stay high for several cycles, so only its rising edge counts
	always_ff @(posedge clk) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= m_ack_i;
	end
	assign ack_pe = m_cyc_o & m_ack_i & ~ack_q;

	// The cycle ends on the clock after the acknowledge
	always_ff @(posedge clk) begin
		if (rst_i) begin
			m_cyc_o <= 1'b0;
			m_we_o <= 1'b0;
		end else if (m_cyc_o) begin
			if (ack_pe)
				m_cyc_o <= 1'b0;
		end else if (wr_dem || rd_dem) begin
			m_cyc_o <= 1'b1;
			m_we_o <= wr_dem;
		end
	end
	assign m_stb_o = m_cyc_o;

	// Address and write data are captured as the cycle starts
	always_ff @(posedge clk) begin
		if (!m_cyc_o && (wr_dem || rd_dem)) begin
			m_adr_o <= wr_dem ? dma.dst_adr : dma.src_adr;
			m_dat_o <= beat_i;
		end
	end

	// One completion pulse per beat, in each direction
	assign dma.wr_beat_done = ack_pe & m_we_o;
	assign dma.rd_beat_done = ack_pe & ~m_we_o;
	assign beat_taken_o = dma.wr_beat_done;

	// Read data goes straight to the transmit buffers with the fill pulse
	assign fill_o = dma.rd_beat_done;
	assign beat_o = m_dat_i;

	// Direction holds for the whole bus cycle
	assert property (@(posedge clk) disable iff (rst_i)
		m_cyc_o && $past(m_cyc_o) |-> $stable(m_we_o));

endmodule

// File: design/pti_gather.sv
// Receive byte packer for the parallel transfer interface
// Collects bytes into a two-half buffer and detects end of transmission
`timescale 1ns/1ps

module pti_gather (
	input  logic clk,
	input  logic rst_i,
	input  logic buf_rst_i,
	input  logic rd_stream_i,
	input  logic check_eot_i,
	input  logic rx_stb_i,
	input  logic [pti_bus_pkg::BYTE_W-1:0] rx_dat_i,
	output logic beat_rdy_o,
	output pti_bus_pkg::beat_t beat_o,
	input  logic beat_taken_i,
	output logic eot_o
);
	import pti_bus_pkg::*;

	// Index bit that selects the buffer half
	localparam int HALF_BIT = $clog2(BEAT_BYTES);

	logic [BYTE_W-1:0] buf_q [0:2*BEAT_BYTES-1];
	logic [HALF_BIT:0] idx;
	logic [1:0] pend;
	logic out_half;
	logic take_byte;

	// Bytes are taken only while the receive stream runs
	assign take_byte = rx_stb_i & rd_stream_i;

	always_ff @(posedge clk) begin
		if (take_byte)
			buf_q[idx] <= rx_dat_i;
	end

	// Filling the last byte of a half hands that half to the bus master.
	// Halves complete in order, so out_half always names the oldest one
	always_ff @(posedge clk) begin
		if (rst_i || buf_rst_i) begin
			idx <= '0;
			pend <= 2'b00;
			out_half <= 1'b0;
		end else begin
			if (beat_taken_i) begin
				pend[out_half] <= 1'b0;
				out_half <= ~out_half;
			end
			if (take_byte) begin
				idx <= idx + 1'b1;
				if (&idx[HALF_BIT-1:0])
					pend[idx[HALF_BIT]] <= 1'b1;
			end
		end
	end

	assign beat_rdy_o = pend[out_half];

	// Byte k of the pending half lands in lane k of the beat
	always_comb begin
		for (int k = 0; k < BEAT_BYTES; k++) begin
			beat_o[BYTE_W*k +: BYTE_W] = buf_q[{out_half, k[HALF_BIT-1:0]}];
		end
	end

	// End of transmission is flagged for one cycle after the byte arrives
	always_ff @(posedge clk) begin
		if (rst_i || buf_rst_i)
			eot_o <= 1'b0;
		else
			eot_o <= take_byte && check_eot_i && rx_dat_i == EOT_CODE;
	end

endmodule

// File: design/pti_unpack.sv
// Transmit unpacker for the parallel transfer interface
// Two beat buffers drained one byte per cycle under port back-pressure
`timescale 1ns/1ps

module pti_unpack (
	input  logic clk,
	input  logic rst_i,
	input  logic buf_rst_i,
	input  logic wr_stream_i,
	input  logic fill_i,
	input  pti_bus_pkg::beat_t beat_i,
	output logic room_o,
	input  logic tx_afull_i,
	output logic tx_stb_o,
	output logic [pti_bus_pkg::BYTE_W-1:0] tx_dat_o
);
	import pti_bus_pkg::*;

	beat_t buf_q [0:1];
	logic [1:0] valid;
	logic wr_sel;
	logic rd_sel;
	logic [$clog2(BEAT_BYTES)-1:0] idx;

	// ------------------------------------------------------------
	// Buffer fill side
	// ------------------------------------------------------------

	// Beats arrive from bus reads and fill the buffers alternately
	always_ff @(posedge clk) begin
		if (fill_i)
			buf_q[wr_sel] <= beat_i;
	end

	// A new read may be started while either buffer is free
	assign room_o = ~&valid;

	// ------------------------------------------------------------
	// Byte output side
	// ------------------------------------------------------------

	// The strobe follows afull in the same cycle, so no byte is lost
	assign tx_stb_o = valid[rd_sel] & wr_stream_i & ~tx_afull_i;
	assign tx_dat_o = buf_q[rd_sel][BYTE_W*idx +: BYTE_W];

	// Sending byte 15 frees the buffer and moves to the other one
	always_ff @(posedge clk) begin
		if (rst_i || buf_rst_i) begin
			valid <= 2'b00;
			wr_sel <= 1'b0;
			rd_sel <= 1'b0;
			idx <= '0;
		end else begin
			if (tx_stb_o) begin
				idx <= idx + 1'b1;
				if (&idx) begin
					valid[rd_sel] <= 1'b0;
					rd_sel <= ~rd_sel;
				end
			end
			if (fill_i) begin
				valid[wr_sel] <= 1'b1;
				wr_sel <= ~wr_sel;
			end
		end
	end

	// The bus master only reads into a free buffer
	assert property (@(posedge clk) disable iff (rst_i || buf_rst_i)
		fill_i |-> room_o);

endmodule

// File: design/pti_top.sv
// Parallel transfer interface top level
// Streaming DMA between a byte-wide port and a 128-bit memory bus
`timescale 1ns/1ps

module pti_top (
	input  logic clk,
	input  logic rst_i,
	// Register slave
	input  logic s_cs_i,
	input  logic s_we_i,
	input  logic [pti_reg_pkg::REG_DW/8-1:0] s_sel_i,
	input  logic [pti_reg_pkg::REG_AW-1:0] s_adr_i,
	input  logic [pti_reg_pkg::REG_DW-1:0] s_dat_i,
	output logic [pti_reg_pkg::REG_DW-1:0] s_dat_o,
	// Memory bus master
	output logic m_cyc_o,
	output logic m_stb_o,
	output logic m_we_o,
	output logic [pti_bus_pkg::BUS_AW-1:0] m_adr_o,
	output logic [pti_bus_pkg::BUS_DW-1:0] m_dat_o,
	input  logic [pti_bus_pkg::BUS_DW-1:0] m_dat_i,
	input  logic m_ack_i,
	// Byte port
	input  logic rx_stb_i,
	input  logic [pti_bus_pkg::BYTE_W-1:0] rx_dat_i,
	output logic tx_stb_o,
	output logic [pti_bus_pkg::BYTE_W-1:0] tx_dat_o,
	input  logic tx_afull_i,
	// Threshold interrupts
	output logic sirq_o,
	output logic dirq_o
);
	import pti_bus_pkg::*;

	beat_t rx_beat;
	beat_t tx_beat;
	logic beat_rdy;
	logic beat_taken;
	logic fill;
	logic room;
	logic eot;
	logic buf_rst;
	logic check_eot;

	pti_dma_if dma ();

	// Status shows the bus and buffer levels
	pti_regs u_regs (
		.clk(clk),
		.rst_i(rst_i),
		.s_cs_i(s_cs_i),
		.s_we_i(s_we_i),
		.s_sel_i(s_sel_i),
		.s_adr_i(s_adr_i),
		.s_dat_i(s_dat_i),
		.s_dat_o(s_dat_o),
		.eot_i(eot),
		.bus_stat_i({m_cyc_o, tx_afull_i, room, beat_rdy}),
		.dma(dma),
		.buf_rst_o(buf_rst),
		.check_eot_o(check_eot),
		.sirq_o(sirq_o),
		.dirq_o(dirq_o)
	);

	pti_master u_master (
		.clk(clk),
		.rst_i(rst_i),
		.dma(dma),
		.beat_rdy_i(beat_rdy),
		.beat_i(rx_beat),
		.beat_taken_o(beat_taken),
		.room_i(room),
		.fill_o(fill),
		.beat_o(tx_beat),
		.m_cyc_o(m_cyc_o),
		.m_stb_o(m_stb_o),
		.m_we_o(m_we_o),
		.m_adr_o(m_adr_o),
		.m_dat_o(m_dat_o),
		.m_dat_i(m_dat_i),
		.m_ack_i(m_ack_i)
	);

	pti_gather u_gather (
		.clk(clk),
		.rst_i(rst_i),
		.buf_rst_i(buf_rst),
		.rd_stream_i(dma.rd_stream),
		.check_eot_i(check_eot),
		.rx_stb_i(rx_stb_i),
		.rx_dat_i(rx_dat_i),
		.beat_rdy_o(beat_rdy),
		.beat_o(rx_beat),
		.beat_taken_i(beat_taken),
		.eot_o(eot)
	);

	pti_unpack u_unpack (
		.clk(clk),
		.rst_i(rst_i),
		.buf_rst_i(buf_rst),
		.wr_stream_i(dma.wr_stream),
		.fill_i(fill),
		.beat_i(tx_beat),
		.room_o(room),
		.tx_afull_i(tx_afull_i),
		.tx_stb_o(tx_stb_o),
		.tx_dat_o(tx_dat_o)
	);

endmodule

// File: test/pti_tb.sv
// Testbench for the parallel transfer interface
// Bus memory model, byte driver, reference functions and result checker
`timescale 1ns/1ps

module pti_tb;
	import pti_bus_pkg::*;
	import pti_reg_pkg::*;

	// The six tests together run for roughly a thousand cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic rst_i;
	logic s_cs_i;
	logic s_we_i;
	logic [REG_DW/8-1:0] s_sel_i;
	logic [REG_AW-1:0] s_adr_i;
	logic [REG_DW-1:0] s_dat_i;
	logic [REG_DW-1:0] s_dat_o;
	logic m_cyc_o;
	logic m_stb_o;
	logic m_we_o;
	logic [BUS_AW-1:0] m_adr_o;
	logic [BUS_DW-1:0] m_dat_o;
	logic [BUS_DW-1:0] m_dat_i;
	logic m_ack_i;
	logic rx_stb_i;
	logic [BYTE_W-1:0] rx_dat_i;
	logic tx_stb_o;
	logic [BYTE_W-1:0] tx_dat_o;
	logic tx_afull_i;
	logic sirq_o;
	logic dirq_o;

	// Shared state of the stimulus, memory model and checker
	logic [31:0] lcg_state = 32'h9b7a;
	logic [7:0] rx_hist [$];
	logic [31:0] exp_adr [$];
	int wr_seen = 0;
	logic [31:0] tx_base = '0;
	int tx_total = 0;
	int tx_seen = 0;
	logic afull_on = 1'b0;
	logic dirq_allowed = 1'b0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;

	pti_top DUT (.*);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ------------------------------------------------------------
	// Reference functions
	// ------------------------------------------------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Memory content, every 32-bit word mixes the whole beat address
	function automatic beat_t mem_word(input logic [31:0] adr);
		beat_t w;
		for (int k = 0; k < 4; k++) begin
			w[32*k +: 32] = (adr * 32'h9e3779b1) ^ {adr[15:0], adr[31:16]} ^
				(32'h01010101 * 32'(k + 1));
		end
		return w;
	endfunction

	// Beat k of the receive stream, first byte in the lowest lane
	function automatic beat_t rx_beat_exp(input int k);
		beat_t b;
		for (int j = 0; j < 16; j++)
			b[8*j +: 8] = rx_hist[16*k + j];
		return b;
	endfunction

	// Byte n of the transmit stream read from successive beats
	function automatic logic [7:0] tx_byte_exp(input logic [31:0] base, input int n);
		beat_t w;
		w = mem_word(base + 32'(16 * (n / 16)));
		return w[8*(n%16) +: 8];
	endfunction

	function automatic logic [63:0] align16(input logic [63:0] v);
		return {32'h0, v[31:4], 4'h0};
	endfunction

	function automatic logic [63:0] ctrl_word(input logic rd, input logic wr,
		input logic sirq_en, input logic dirq_en, input logic eot);
		logic [63:0] c;
		c = '0;
		c[CTL_RD_STREAM] = rd;
		c[CTL_WR_STREAM] = wr;
		c[CTL_SIRQ_EN] = sirq_en;
		c[CTL_DIRQ_EN] = dirq_en;
		c[CTL_CHECK_EOT] = eot;
		return c;
	endfunction

	// ------------------------------------------------------------
	// Checks and bus tasks
	// ------------------------------------------------------------
	task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Every tb task starts and ends 1 ns after a rising edge
	task automatic idle(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [63:0] data, input logic [7:0] sel);
		s_cs_i = 1'b1;
		s_we_i = 1'b1;
		s_adr_i = adr;
		s_dat_i = data;
		s_sel_i = sel;
		idle(1);
		s_cs_i = 1'b0;
		s_we_i = 1'b0;
		s_sel_i = '0;
	endtask

	// Read data is registered on the edge that sees chip select
	task automatic read_reg(input logic [2:0] adr, output logic [63:0] data);
		s_cs_i = 1'b1;
		s_we_i = 1'b0;
		s_adr_i = adr;
		idle(1);
		data = s_dat_o;
		s_cs_i = 1'b0;
	endtask

	// Random bytes, one per cycle; only position eot_at carries the EOT code
	task automatic send_rx(input int n, input int eot_at);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = 8'(lcg_next() >> 16);
			if (b == EOT_CODE)
				b = 8'h44;
			if (i == eot_at)
				b = EOT_CODE;
			rx_hist.push_back(b);
			rx_stb_i = 1'b1;
			rx_dat_i = b;
			idle(1);
			rx_stb_i = 1'b0;
		end
	endtask

	task automatic wait_writes();
		int n;
		n = 0;
		while (exp_adr.size() != 0 && n < 300) begin
			idle(1);
			n++;
		end
		assert (exp_adr.size() == 0) else begin
			errors++;
			$display("ERROR: %0d expected bus writes never appeared", exp_adr.size());
		end
		// Let the last acknowledge reach the counters
		idle(4);
	endtask

	// Compares one bus write with the next expected address and beat
	task automatic check_write();
		assert (exp_adr.size() != 0) else begin
			errors++;
			$display("ERROR: unexpected bus write to address %h at %0t", m_adr_o, $time);
		end
		if (exp_adr.size() != 0) begin
			check_eq(m_adr_o, exp_adr.pop_front(), "write address");
			check_eq(m_dat_o, rx_beat_exp(wr_seen), "write data");
			wr_seen++;
		end
	endtask

	// ------------------------------------------------------------
	// Bus memory with a random acknowledge delay of 0 to 3 cycles
	// ------------------------------------------------------------
	initial begin : bus_memory
		int wait_left;
		logic busy;
		m_ack_i = 1'b0;
		m_dat_i = '0;
		busy = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge clk);
			#1;
			// The master ends its cycle on the edge that saw the ack
			if (m_ack_i) begin
				m_ack_i = 1'b0;
			end else if (m_cyc_o === 1'b1 && m_stb_o === 1'b1) begin
				if (!busy) begin
					busy = 1'b1;
					wait_left = int'((lcg_next() >> 16) % 32'd4);
				end
				if (wait_left == 0) begin
					busy = 1'b0;
					m_ack_i = 1'b1;
					if (m_we_o)
						check_write();
					else
						m_dat_i = mem_word(m_adr_o);
				end else begin
					wait_left--;
				end
			end
		end
	end

	// Back-pressure from the byte port while enabled
	initial begin : afull_driver
		tx_afull_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (afull_on)
				tx_afull_i = ((lcg_next() >> 20) % 32'd3) == 32'd0;
			else
				tx_afull_i = 1'b0;
		end
	end

	// Outputs are sampled mid-cycle, where they are stable
	always @(negedge clk) begin
		if (!rst_i) begin
			if (tx_stb_o === 1'b1) begin
				check_eq(tx_afull_i, 1'b0, "tx_afull_i under a tx strobe");
				assert (tx_seen < tx_total) else begin
					errors++;
					$display("ERROR: tx byte strobed beyond the %0d expected at %0t", tx_total, $time);
				end
				if (tx_seen < tx_total)
					check_eq(tx_dat_o, tx_byte_exp(tx_base, tx_seen), "tx byte");
				tx_seen++;
			end
			check_eq(sirq_o, 1'b0, "sirq_o with its flag clear or enable off");
			if (!dirq_allowed)
				check_eq(dirq_o, 1'b0, "dirq_o with its enable off");
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------
	initial begin : main_sequence
		logic [63:0] rd;
		int n;
		rst_i = 1'b1;
		s_cs_i = 1'b0;
		s_we_i = 1'b0;
		s_sel_i = '0;
		s_adr_i = '0;
		s_dat_i = '0;
		rx_stb_i = 1'b0;
		rx_dat_i = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_i = 1'b0;
		idle(2);

		// Reset state
		check_eq(m_cyc_o, 1'b0, "m_cyc_o after reset");
		read_reg(REG_DST_CNT, rd);
		check_eq(rd, 64'hFFF0, "dst_cnt after reset");
		read_reg(REG_SRC_CNT, rd);
		check_eq(rd, 64'hFFF0, "src_cnt after reset");
		read_reg(REG_CTRL, rd);
		check_eq(rd, ctrl_word(0, 0, 0, 0, 1), "control after reset");

		// Register readback with beat alignment
		write_reg(REG_DST_ADR, 64'h1234_567F, 8'hFF);
		write_reg(REG_DST_CNT, 64'h0000_0ABC, 8'hFF);
		write_reg(REG_SRC_ADR, 64'hDEAD_BEEF, 8'hFF);
		write_reg(REG_SRC_CNT, 64'h0000_1F1F, 8'hFF);
		read_reg(REG_DST_ADR, rd);
		check_eq(rd, align16(64'h1234_567F), "dst_adr readback");
		read_reg(REG_DST_CNT, rd);
		check_eq(rd, align16(64'h0000_0ABC), "dst_cnt readback");
		read_reg(REG_SRC_ADR, rd);
		check_eq(rd, align16(64'hDEAD_BEEF), "src_adr readback");
		read_reg(REG_SRC_CNT, rd);
		check_eq(rd, align16(64'h0000_1F1F), "src_cnt readback");
		// Source count is far from its zero threshold, so sirq_o stays low
		write_reg(REG_CTRL, ctrl_word(1, 0, 1, 1, 0), 8'hFF);
		read_reg(REG_CTRL, rd);
		check_eq(rd, ctrl_word(1, 0, 1, 1, 0), "control readback");
		write_reg(REG_CTRL, ctrl_word(0, 0, 0, 0, 1), 8'hFF);
		read_reg(REG_CTRL, rd);
		check_eq(rd, ctrl_word(0, 0, 0, 0, 1), "control readback");

		// Receive stream of four beats
		rx_hist.delete();
		wr_seen = 0;
		write_reg(REG_DST_ADR, 64'h1000, 8'hFF);
		write_reg(REG_DST_CNT, 64'd64, 8'hFF);
		for (int k = 0; k < 4; k++)
			exp_adr.push_back(32'h1000 + 32'(16 * k));
		write_reg(REG_CTRL, ctrl_word(1, 0, 0, 0, 1), 8'hFF);
		send_rx(64, -1);
		wait_writes();
		read_reg(REG_DST_CNT, rd);
		check_eq(rd, 64'd0, "dst_cnt after receive");
		read_reg(REG_CTRL, rd);
		check_eq(rd, ctrl_word(0, 0, 0, 0, 1), "control after receive");

		// EOT as the last byte of beat 1 halts the stream after that beat
		rx_hist.delete();
		wr_seen = 0;
		write_reg(REG_DST_ADR, 64'h2000, 8'hFF);
		write_reg(REG_DST_CNT, 64'd64, 8'hFF);
		exp_adr.push_back(32'h2000);
		exp_adr.push_back(32'h2010);
		write_reg(REG_CTRL, ctrl_word(1, 0, 0, 0, 1), 8'hFF);
		send_rx(40, 31);
		wait_writes();
		idle(10);
		check_eq(wr_seen, 2, "writes in the EOT stream");
		read_reg(REG_DST_ADR, rd);
		check_eq(rd, 64'h2010, "dst_adr after EOT");
		read_reg(REG_CTRL, rd);
		check_eq(rd, ctrl_word(0, 0, 0, 0, 1), "control after EOT");

		// Software reset drops the bytes that followed EOT
		write_reg(REG_CTRL, 64'd1 << CTL_SWRST, 8'h08);
		idle(SWRST_CYCLES + 2);

		// Transmit stream of three beats under random back-pressure
		write_reg(REG_SRC_ADR, 64'h8000, 8'hFF);
		write_reg(REG_SRC_CNT, 64'd48, 8'hFF);
		tx_base = 32'h8000;
		tx_total = 48;
		tx_seen = 0;
		afull_on = 1'b1;
		write_reg(REG_CTRL, ctrl_word(0, 1, 0, 0, 1), 8'hFF);
		n = 0;
		while (tx_seen < tx_total && n < 400) begin
			idle(1);
			n++;
		end
		idle(20);
		check_eq(tx_seen, 48, "tx byte count");
		read_reg(REG_SRC_CNT, rd);
		check_eq(rd, 64'd0, "src_cnt after transmit");
		afull_on = 1'b0;
		write_reg(REG_CTRL, ctrl_word(0, 0, 0, 0, 1), 8'hFF);

		// Destination threshold interrupt at a count of 32
		rx_hist.delete();
		wr_seen = 0;
		write_reg(REG_THRES, 64'd32 << 32, 8'hFF);
		write_reg(REG_DST_ADR, 64'h3000, 8'hFF);
		write_reg(REG_DST_CNT, 64'd64, 8'hFF);
		for (int k = 0; k < 4; k++)
			exp_adr.push_back(32'h3000 + 32'(16 * k));
		write_reg(REG_CTRL, ctrl_word(1, 0, 0, 1, 1), 8'hFF);
		dirq_allowed = 1'b1;
		send_rx(32, -1);
		n = 0;
		do begin
			read_reg(REG_DST_CNT, rd);
			n++;
		end while (rd != 64'd32 && n < 100);
		check_eq(rd, 64'd32, "dst_cnt at threshold");
		check_eq(dirq_o, 1'b1, "dirq_o at threshold");
		send_rx(32, -1);
		wait_writes();
		read_reg(REG_DST_CNT, rd);
		check_eq(rd, 64'd0, "dst_cnt after interrupt stream");
		check_eq(dirq_o, 1'b1, "dirq_o held until acknowledged");
		write_reg(REG_CTRL, ctrl_word(0, 0, 0, 1, 1), 8'hFF);
		idle(2);
		check_eq(dirq_o, 1'b0, "dirq_o after control write");

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: pti_top.f
design/pti_bus_pkg.sv
design/pti_reg_pkg.sv
design/pti_dma_if.sv
design/pti_regs.sv
design/pti_master.sv
design/pti_gather.sv
design/pti_unpack.sv
design/pti_top.sv
test/pti_tb.sv

// File: Makefile
# Verilator build and run for the parallel transfer interface

VERILATOR ?= verilator
TB_TOP ?= pti_tb
RTL_TOP ?= pti_top
FILELIST ?= pti_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
